// File: verilog/exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

//////////////////////////////////////////////////////////////
// Execute unit widths
//////////////////////////////////////////////////////////////

// Operand and result width
`define EXU_DATA_W 32

// Shift amount, constant or taken from opA
`define EXU_SHAMT_W 5

// Operation code width, 24 codes in use
`define EXU_OP_W 5

//////////////////////////////////////////////////////////////
// Multiplier timing
//////////////////////////////////////////////////////////////

// Cycles from accepting edge to done
// Operand stage plus product stage
`define EXU_MUL_LAT 2

// Counter width for the multiply in flight
`define EXU_MUL_CNT_W 2

`endif

// File: verilog/exuPkg.sv
`include "exu_macros.svh"

package exuPkg;

	// Operation codes, 0..21 follow the ALU table
	typedef enum logic [`EXU_OP_W-1:0] {
		opAdd   = 5'd0,
		opSub   = 5'd1,
		opMult  = 5'd2,
		opAnd   = 5'd3,
		opOr    = 5'd4,
		opXor   = 5'd5,
		opNor   = 5'd6,
		opSll   = 5'd7,
		opSrl   = 5'd8,
		opRotr  = 5'd9,
		opSra   = 5'd10,
		opSeh   = 5'd11,
		opAddu  = 5'd12,
		opMultu = 5'd13,
		opSlt   = 5'd14,
		opSeb   = 5'd15,
		opSltu  = 5'd16,
		opSllv  = 5'd17,
		opSrlv  = 5'd18,
		opSrav  = 5'd19,
		opRotrv = 5'd20,
		opMove  = 5'd21,
		opMfhi  = 5'd22, // HI readback
		opMflo  = 5'd23  // LO readback
	} aluOpE;

	// Result source
	typedef enum logic [1:0] {unitAlu, unitShift, unitMul, unitHiLo} unitSelE;

	// ALU core function
	typedef enum logic [2:0] {fnAdd, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnExt, fnPass} aluFnE;

	typedef enum logic [1:0] {shLeft, shRightLogic, shRightArith, shRotate} shiftKindE;

	// Decoded control, one per issued code
	typedef struct packed {
		unitSelE   unitSel;
		aluFnE     aluFn;
		logic      subtract;    // Invert B, carry in
		logic      isSigned;    // Signed compare / multiply
		shiftKindE shiftKind;
		logic      useVarShamt; // Amount from opA[4:0]
		logic      extHalf;     // Half word, else byte
		logic      mulStart;
		logic      hiLoWrite;   // Move writes HI and LO
		logic      readHi;
	} exuCtlS;

	// Output stage payload
	typedef struct packed {
		logic [`EXU_DATA_W-1:0] data;
		logic                   zero;
	} exuResS;

endpackage

// File: verilog/exuControl.sv
`timescale 1ns/10ps
`include "exu_macros.svh"

module exuControl (
	input  logic           clk,
	input  logic           rstN,
	input  logic           issue,
	input  exuPkg::aluOpE  aluCtl,
	output exuPkg::exuCtlS ctl,
	output logic           accept,
	output logic           mulAccept,
	output logic           done,
	output logic           busy
);

	logic [`EXU_MUL_CNT_W-1:0] mulCnt; // Cycles left in flight
	logic mulLast;

	//////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////
	always_comb begin
		ctl = '0; // ALU add, all flags clear
		case (aluCtl)
			exuPkg::opAdd:   ctl.isSigned = 1'b1;
			exuPkg::opSub:   ctl.subtract = 1'b1;
			exuPkg::opAddu:  ctl.aluFn = exuPkg::fnAdd;
			exuPkg::opAnd:   ctl.aluFn = exuPkg::fnAnd;
			exuPkg::opOr:    ctl.aluFn = exuPkg::fnOr;
			exuPkg::opXor:   ctl.aluFn = exuPkg::fnXor;
			exuPkg::opNor:   ctl.aluFn = exuPkg::fnNor;
			exuPkg::opSlt,
			exuPkg::opSltu: begin
				ctl.aluFn    = exuPkg::fnSlt;
				ctl.subtract = 1'b1; // Compare via A - B
				ctl.isSigned = (aluCtl == exuPkg::opSlt);
			end
			exuPkg::opSeh,
			exuPkg::opSeb: begin
				ctl.aluFn   = exuPkg::fnExt;
				ctl.extHalf = (aluCtl == exuPkg::opSeh);
			end
			exuPkg::opSll, exuPkg::opSrl, exuPkg::opSra, exuPkg::opRotr,
			exuPkg::opSllv, exuPkg::opSrlv, exuPkg::opSrav, exuPkg::opRotrv: begin
				ctl.unitSel     = exuPkg::unitShift;
				ctl.useVarShamt = aluCtl inside {exuPkg::opSllv, exuPkg::opSrlv,
					exuPkg::opSrav, exuPkg::opRotrv};
				if (aluCtl inside {exuPkg::opSrl, exuPkg::opSrlv})
					ctl.shiftKind = exuPkg::shRightLogic;
				else if (aluCtl inside {exuPkg::opSra, exuPkg::opSrav})
					ctl.shiftKind = exuPkg::shRightArith;
				else if (aluCtl inside {exuPkg::opRotr, exuPkg::opRotrv})
					ctl.shiftKind = exuPkg::shRotate;
			end
			exuPkg::opMult,
			exuPkg::opMultu: begin
				ctl.unitSel  = exuPkg::unitMul;
				ctl.mulStart = 1'b1;
				ctl.isSigned = (aluCtl == exuPkg::opMult);
			end
			exuPkg::opMove: begin
				ctl.aluFn     = exuPkg::fnPass; // Pass opA
				ctl.hiLoWrite = 1'b1;
			end
			exuPkg::opMfhi: begin
				ctl.unitSel = exuPkg::unitHiLo;
				ctl.readHi  = 1'b1;
			end
			exuPkg::opMflo:  ctl.unitSel = exuPkg::unitHiLo;
			default:         ctl.aluFn = exuPkg::fnPass; // Constant 1
		endcase
	end

	assign accept    = issue & ~busy; // Issue while busy is dropped
	assign mulAccept = accept & ctl.mulStart;
	assign mulLast   = busy && (mulCnt == `EXU_MUL_CNT_W'(1));

	//////////////////////////////////////////////////////////////
	// Multiply in flight and done
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy   <= 1'b0;
			done   <= 1'b0;
			mulCnt <= '0;
		end else begin
			done <= (accept & ~ctl.mulStart) | mulLast; // Single source of done
			if (mulAccept) begin
				busy   <= 1'b1;
				mulCnt <= `EXU_MUL_CNT_W'(`EXU_MUL_LAT - 1);
			end else if (busy) begin
				if (mulCnt == '0)
					busy <= 1'b0; // Done cycle just ended
				else
					mulCnt <= mulCnt - 1'b1;
			end
		end
	end

endmodule

// File: verilog/aluCore.sv
`timescale 1ns/10ps
`include "exu_macros.svh"

module aluCore (
	input  exuPkg::exuCtlS         ctl,
	input  logic [`EXU_DATA_W-1:0] opA,
	input  logic [`EXU_DATA_W-1:0] opB,
	output logic [`EXU_DATA_W-1:0] aluOut
);

	logic [`EXU_DATA_W-1:0] bIn;
	logic [`EXU_DATA_W-1:0] sum;
	logic carry;
	logic overflow;
	logic lessThan;
	logic [`EXU_DATA_W-1:0] extOut;

	//////////////////////////////////////////////////////////////
	// Shared adder
	//////////////////////////////////////////////////////////////
	assign bIn = ctl.subtract ? ~opB : opB;
	assign {carry, sum} = {1'b0, opA} + {1'b0, bIn} + {{`EXU_DATA_W{1'b0}}, ctl.subtract};

	// Signed overflow on A - B
	assign overflow = (opA[`EXU_DATA_W-1] ^ opB[`EXU_DATA_W-1]) &
		(sum[`EXU_DATA_W-1] ^ opA[`EXU_DATA_W-1]);

	// Signed: sign of difference, corrected; unsigned: borrow
	assign lessThan = ctl.isSigned ? (sum[`EXU_DATA_W-1] ^ overflow) : ~carry;

	// seh / seb on opB
	assign extOut = ctl.extHalf ?
		{{(`EXU_DATA_W-16){opB[15]}}, opB[15:0]} :
		{{(`EXU_DATA_W-8){opB[7]}}, opB[7:0]};

	//////////////////////////////////////////////////////////////
	// Function select
	//////////////////////////////////////////////////////////////
	always_comb begin
		case (ctl.aluFn)
			exuPkg::fnAdd: aluOut = sum; // add, addu, sub
			exuPkg::fnAnd: aluOut = opA & opB;
			exuPkg::fnOr:  aluOut = opA | opB;
			exuPkg::fnXor: aluOut = opA ^ opB;
			exuPkg::fnNor: aluOut = ~(opA | opB);
			exuPkg::fnSlt: aluOut = {{(`EXU_DATA_W-1){1'b0}}, lessThan};
			exuPkg::fnExt: aluOut = extOut;
			default: begin
				// Move passes opA, unknown codes give 1
				if (ctl.hiLoWrite)
					aluOut = opA;
				else
					aluOut = `EXU_DATA_W'(1);
			end
		endcase
	end

endmodule

// File: verilog/barrelShifter.sv
`timescale 1ns/10ps
`include "exu_macros.svh"

module barrelShifter (
	input  exuPkg::exuCtlS          ctl,
	input  logic [`EXU_DATA_W-1:0]  opA,
	input  logic [`EXU_DATA_W-1:0]  opB,
	input  logic [`EXU_SHAMT_W-1:0] shamt,
	output logic [`EXU_DATA_W-1:0]  shOut
);

	logic [`EXU_SHAMT_W-1:0] amt;
	logic [2*`EXU_DATA_W-1:0] rotWide; // opB twice, for rotate

	// Variable forms use only opA[4:0]
	assign amt = ctl.useVarShamt ? opA[`EXU_SHAMT_W-1:0] : shamt;

	// Low half of {opB, opB} >> amt is the rotation, amt 0 gives opB
	assign rotWide = {opB, opB} >> amt;

	//////////////////////////////////////////////////////////////
	// Shift kind
	//////////////////////////////////////////////////////////////
	always_comb begin
		case (ctl.shiftKind)
			exuPkg::shLeft:
				shOut = opB << amt;
			exuPkg::shRightLogic:
				shOut = opB >> amt;
			exuPkg::shRightArith:
				shOut = $signed(opB) >>> amt; // Sign fill
			default:
				shOut = rotWide[`EXU_DATA_W-1:0];
		endcase
	end

endmodule

// File: verilog/mulHiLo.sv
`timescale 1ns/10ps
`include "exu_macros.svh"

module mulHiLo (
	input  logic                   clk,
	input  logic                   rstN,
	input  exuPkg::exuCtlS         ctl,
	input  logic                   mulAccept,
	input  logic                   moveAccept,
	input  logic [`EXU_DATA_W-1:0] opA,
	input  logic [`EXU_DATA_W-1:0] opB,
	output logic [`EXU_DATA_W-1:0] loOut,
	output logic [`EXU_DATA_W-1:0] hiLoOut
);

	logic signed [`EXU_DATA_W:0] aReg; // One extra bit for signedness
	logic signed [`EXU_DATA_W:0] bReg;
	logic mulValid; // Stage 1 holds operands
	logic signed [2*`EXU_DATA_W-1:0] prod;
	logic [`EXU_DATA_W-1:0] hiReg;
	logic [`EXU_DATA_W-1:0] loReg;

	//////////////////////////////////////////////////////////////
	// Stage 1, operands
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			mulValid <= 1'b0;
		else
			mulValid <= mulAccept;
	end

	always_ff @(posedge clk) begin
		if (mulAccept) begin
			// multu extends with 0, mult with the sign bit
			aReg <= {ctl.isSigned & opA[`EXU_DATA_W-1], opA};
			bReg <= {ctl.isSigned & opB[`EXU_DATA_W-1], opB};
		end
	end

	// 33 x 33 signed, low 64 bits are exact for both forms
	assign prod = aReg * bReg;
	assign loOut = prod[`EXU_DATA_W-1:0];

	//////////////////////////////////////////////////////////////
	// Stage 2, HI/LO
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hiReg <= '0;
			loReg <= '0;
		end else if (mulValid) begin
			hiReg <= prod[2*`EXU_DATA_W-1:`EXU_DATA_W];
			loReg <= prod[`EXU_DATA_W-1:0];
		end else if (moveAccept) begin
			hiReg <= opA; // Move fills both
			loReg <= opA;
		end
	end

	assign hiLoOut = ctl.readHi ? hiReg : loReg; // mfhi / mflo

endmodule

// File: verilog/stageReg.sv
`timescale 1ns/10ps

module stageReg #(
	parameter type     payloadT = exuPkg::exuResS,
	parameter payloadT resetVal = '0
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    load,
	input  payloadT d,
	output payloadT q
);

	//////////////////////////////////////////////////////////////
	// Loadable register
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			q <= resetVal; // Per payload
		else if (load)
			q <= d;
		// Otherwise hold
	end

endmodule

// File: verilog/executeUnit.sv
`timescale 1ns/10ps
`include "exu_macros.svh"

module executeUnit (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    issue,
	input  exuPkg::aluOpE           aluCtl,
	input  logic [`EXU_DATA_W-1:0]  opA,
	input  logic [`EXU_DATA_W-1:0]  opB,
	input  logic [`EXU_SHAMT_W-1:0] shamt,
	output logic [`EXU_DATA_W-1:0]  result,
	output logic                    zero,
	output logic                    done,
	output logic                    busy
);

	localparam exuPkg::exuResS ResReset = '{data: '0, zero: 1'b1};

	exuPkg::exuCtlS ctl;
	logic accept, mulAccept, moveAccept;
	logic outLoad, mulLoad;
	logic lastMul; // Mul stage loaded more recently
	logic [`EXU_DATA_W-1:0] aluOut, shOut, loOut, hiLoOut, selData;
	exuPkg::exuResS selRes, mulRes, outQ, mulQ;

	exuControl ctl0 (.clk, .rstN, .issue, .aluCtl, .ctl, .accept, .mulAccept, .done, .busy);

	aluCore alu0 (.ctl, .opA, .opB, .aluOut);

	barrelShifter shift0 (.ctl, .opA, .opB, .shamt, .shOut);

	mulHiLo mul0 (.clk, .rstN, .ctl, .mulAccept, .moveAccept, .opA, .opB, .loOut, .hiLoOut);

	//////////////////////////////////////////////////////////////
	// Result select and output stages
	//////////////////////////////////////////////////////////////
	assign moveAccept = accept & ctl.hiLoWrite;
	assign outLoad    = accept & ~ctl.mulStart;
	assign mulLoad    = busy & ~done; // Product completes this edge

	assign selData = (ctl.unitSel == exuPkg::unitShift) ? shOut :
		(ctl.unitSel == exuPkg::unitHiLo) ? hiLoOut : aluOut;
	assign selRes = '{data: selData, zero: (selData == '0)};
	assign mulRes = '{data: loOut, zero: (loOut == '0)}; // Zero refers to LO

	stageReg #(.resetVal(ResReset)) outStage0 (.clk, .rstN, .load(outLoad), .d(selRes),
		.q(outQ));

	stageReg #(.resetVal(ResReset)) mulStage0 (.clk, .rstN, .load(mulLoad), .d(mulRes),
		.q(mulQ));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			lastMul <= 1'b0;
		else if (mulLoad)
			lastMul <= 1'b1;
		else if (outLoad)
			lastMul <= 1'b0;
	end

	assign result = lastMul ? mulQ.data : outQ.data;
	assign zero   = lastMul ? mulQ.zero : outQ.zero;

endmodule

// File: tb/executeUnit_asserts.sv
`timescale 1ns/10ps
`include "exu_macros.svh"

module executeUnitAsserts (
	input logic                   clk,
	input logic                   rstN,
	input logic                   done,
	input logic                   busy,
	input logic                   zero,
	input logic [`EXU_DATA_W-1:0] result
);

	int assertFails = 0; // Failure count, read by the testbench
	int busyCycles;      // Busy cycles seen without done

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			busyCycles <= 0;
		else if (busy && !done)
			busyCycles <= busyCycles + 1;
		else
			busyCycles <= 0;
	end

	//////////////////////////////////////////////////////////////
	// Handshake and flag rules
	//////////////////////////////////////////////////////////////

	// Multiply done is a single pulse, issues during busy are dropped
	singleMulDone: assert property (@(posedge clk) disable iff (!rstN)
		(busy && done) |=> !done)
		else begin
			assertFails++;
			$error("done stayed high after a multiply done");
		end

	// Busy ends in done within the multiply latency
	busyBounded: assert property (@(posedge clk) disable iff (!rstN)
		busy |-> (busyCycles < `EXU_MUL_LAT))
		else begin
			assertFails++;
			$error("busy without done for longer than the multiply latency");
		end

	zeroFlag: assert property (@(posedge clk) disable iff (!rstN)
		done |-> (zero == (result == '0))) // Zero follows the result
		else begin
			assertFails++;
			$error("zero flag disagrees with result while done is high");
		end

endmodule

// File: tb/executeUnitTb.sv
`timescale 1ns/10ps
`include "exu_macros.svh"

module executeUnitTb;

	localparam int WaitLimit = 20; // Cycles before any wait gives up

	logic clk;
	logic rstN;
	logic issue;
	exuPkg::aluOpE aluCtl;
	logic [`EXU_DATA_W-1:0] opA;
	logic [`EXU_DATA_W-1:0] opB;
	logic [`EXU_SHAMT_W-1:0] shamt;
	logic [`EXU_DATA_W-1:0] result;
	logic zero;
	logic done;
	logic busy;

	int mismatches = 0;
	int timeouts = 0;
	logic [`EXU_DATA_W-1:0] modelHi = '0; // Reference HI/LO
	logic [`EXU_DATA_W-1:0] modelLo = '0;

	executeUnit dut0 (.clk, .rstN, .issue, .aluCtl, .opA, .opB, .shamt, .result, .zero,
		.done, .busy);

	bind executeUnit executeUnitAsserts asserts0 (.clk(clk), .rstN(rstN), .done(done),
		.busy(busy), .zero(zero), .result(result));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	//////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////

	// Full 64-bit product for mult and multu
	function automatic logic [2*`EXU_DATA_W-1:0] product(input logic isSigned,
		input logic [`EXU_DATA_W-1:0] a, input logic [`EXU_DATA_W-1:0] b);
		logic [2*`EXU_DATA_W-1:0] aWide;
		logic [2*`EXU_DATA_W-1:0] bWide;
		aWide = isSigned ? {{`EXU_DATA_W{a[`EXU_DATA_W-1]}}, a} : {{`EXU_DATA_W{1'b0}}, a};
		bWide = isSigned ? {{`EXU_DATA_W{b[`EXU_DATA_W-1]}}, b} : {{`EXU_DATA_W{1'b0}}, b};
		return aWide * bWide; // Low 64 bits exact either way
	endfunction

	function automatic logic [`EXU_DATA_W-1:0] rotateRight(input logic [`EXU_DATA_W-1:0] b,
		input logic [`EXU_SHAMT_W-1:0] amt);
		return (b >> amt) | (b << (`EXU_DATA_W - amt)); // Amount 0 gives b
	endfunction

	function automatic logic [`EXU_DATA_W-1:0] expectedResult(input exuPkg::aluOpE op,
		input logic [`EXU_DATA_W-1:0] a, input logic [`EXU_DATA_W-1:0] b,
		input logic [`EXU_SHAMT_W-1:0] sh);
		logic [`EXU_SHAMT_W-1:0] va;
		va = a[`EXU_SHAMT_W-1:0]; // Variable amount
		case (op)
			exuPkg::opAdd, exuPkg::opAddu: return a + b;
			exuPkg::opSub:   return a - b;
			exuPkg::opAnd:   return a & b;
			exuPkg::opOr:    return a | b;
			exuPkg::opXor:   return a ^ b;
			exuPkg::opNor:   return ~(a | b);
			exuPkg::opSlt:   return `EXU_DATA_W'($signed(a) < $signed(b));
			exuPkg::opSltu:  return `EXU_DATA_W'(a < b);
			exuPkg::opSeb:   return {{24{b[7]}}, b[7:0]};
			exuPkg::opSeh:   return {{16{b[15]}}, b[15:0]};
			exuPkg::opSll:   return b << sh;
			exuPkg::opSllv:  return b << va;
			exuPkg::opSrl:   return b >> sh;
			exuPkg::opSrlv:  return b >> va;
			exuPkg::opSra:   return $signed(b) >>> sh;
			exuPkg::opSrav:  return $signed(b) >>> va;
			exuPkg::opRotr:  return rotateRight(b, sh);
			exuPkg::opRotrv: return rotateRight(b, va);
			exuPkg::opMult:  return product(1'b1, a, b) & 64'hFFFF_FFFF; // LO
			exuPkg::opMultu: return product(1'b0, a, b) & 64'hFFFF_FFFF;
			exuPkg::opMove:  return a;
			exuPkg::opMfhi:  return modelHi;
			exuPkg::opMflo:  return modelLo;
			default:         return `EXU_DATA_W'(1);
		endcase
	endfunction

	//////////////////////////////////////////////////////////////
	// Check and wait helpers
	//////////////////////////////////////////////////////////////
	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic waitNotBusy();
		int cycles = 0;
		while (busy && cycles < WaitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (busy) begin
			timeouts++;
			$display("Timeout: busy stayed high for %0d cycles", WaitLimit);
		end
	endtask

	// Issues one code and compares result, zero and latency at done
	task automatic runOp(input exuPkg::aluOpE op, input logic [`EXU_DATA_W-1:0] a,
		input logic [`EXU_DATA_W-1:0] b, input logic [`EXU_SHAMT_W-1:0] sh);
		logic [`EXU_DATA_W-1:0] exp;
		logic isMul;
		int lat = 1;
		exp = expectedResult(op, a, b, sh);
		isMul = (op == exuPkg::opMult) || (op == exuPkg::opMultu);
		@(negedge clk);
		waitNotBusy();
		checkValue("done", 32'(done), 32'd0); // Previous pulse is over
		issue  = 1'b1;
		aluCtl = op;
		opA    = a;
		opB    = b;
		shamt  = sh;
		@(negedge clk);
		issue = 1'b0;
		while (!done && lat < WaitLimit) begin
			@(negedge clk);
			lat++;
		end
		if (!done) begin
			timeouts++;
			$display("Timeout: no done after issue of code %0d", op);
		end else begin
			checkValue("latency", 32'(lat), isMul ? 32'(`EXU_MUL_LAT) : 32'd1);
			checkValue("result", result, exp);
			checkValue("zero", 32'(zero), 32'(exp == '0));
		end
		if (isMul)
			{modelHi, modelLo} = product(op == exuPkg::opMult, a, b);
		else if (op == exuPkg::opMove) begin
			modelHi = a; // Move fills both
			modelLo = a;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////
	task automatic resetTest();
		logic [`EXU_DATA_W-1:0] a;
		checkValue("result", result, 32'h0);
		checkValue("zero", 32'(zero), 32'd1);
		checkValue("done", 32'(done), 32'd0);
		checkValue("busy", 32'(busy), 32'd0);
		runOp(exuPkg::opMfhi, $urandom(), $urandom(), 5'd0); // HI and LO cleared
		runOp(exuPkg::opMflo, $urandom(), $urandom(), 5'd0);
		a = $urandom();
		runOp(exuPkg::opSub, a, a, 5'd0); // Zero set
		runOp(exuPkg::opXor, a, a, 5'd0);
	endtask

	// Back to back issues with each result due one cycle later
	task automatic aluStreamTest();
		exuPkg::aluOpE ops[12];
		logic [`EXU_DATA_W-1:0] a;
		logic [`EXU_DATA_W-1:0] b;
		logic [`EXU_DATA_W-1:0] exp;
		ops = '{exuPkg::opAdd, exuPkg::opSub, exuPkg::opAddu, exuPkg::opAnd, exuPkg::opOr,
			exuPkg::opXor, exuPkg::opNor, exuPkg::opSlt, exuPkg::opSltu, exuPkg::opSeb,
			exuPkg::opSeh, exuPkg::aluOpE'(5'd27)};
		@(negedge clk);
		waitNotBusy();
		for (int i = 0; i < 36; i++) begin
			a = $urandom();
			b = (i >= 12 && i < 24) ? a : $urandom(); // Middle round with equal operands
			exp = expectedResult(ops[i % 12], a, b, 5'd0);
			issue  = 1'b1;
			aluCtl = ops[i % 12];
			opA    = a;
			opB    = b;
			shamt  = $urandom();
			@(negedge clk);
			checkValue("done", 32'(done), 32'd1);
			checkValue("result", result, exp);
			checkValue("zero", 32'(zero), 32'(exp == '0));
		end
		issue = 1'b0;
	endtask

	task automatic shiftTest();
		exuPkg::aluOpE constOps[4];
		exuPkg::aluOpE varOps[4];
		logic [`EXU_SHAMT_W-1:0] amts[6];
		logic [`EXU_DATA_W-1:0] b;
		constOps = '{exuPkg::opSll, exuPkg::opSrl, exuPkg::opSra, exuPkg::opRotr};
		varOps   = '{exuPkg::opSllv, exuPkg::opSrlv, exuPkg::opSrav, exuPkg::opRotrv};
		amts     = '{5'd0, 5'd1, 5'd8, 5'd17, 5'd31, 5'd0};
		amts[5]  = $urandom();
		for (int k = 0; k < 4; k++) begin
			for (int j = 0; j < 6; j++) begin
				b = (j % 2) ? ($urandom() | 32'h8000_0000) : ($urandom() & 32'h7FFF_FFFF);
				runOp(constOps[k], $urandom(), b, amts[j]);
				// Upper opA bits and shamt must not matter here
				runOp(varOps[k], {27'($urandom()), amts[j]}, b, ~amts[j]);
			end
		end
	endtask

	task automatic multTest();
		logic [`EXU_DATA_W-1:0] as[8];
		logic [`EXU_DATA_W-1:0] bs[8];
		as = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000,
			32'h8000_0001, 32'h0, 32'h0};
		bs = '{32'h8000_0000, 32'h0000_0001, 32'h8000_0000, 32'hFFFF_FFFF, 32'h1234_5678,
			32'h7FFF_FFFF, 32'h0, 32'h0};
		for (int i = 6; i < 8; i++) begin
			as[i] = $urandom(); // Random tail
			bs[i] = $urandom();
		end
		for (int i = 0; i < 8; i++) begin
			runOp(exuPkg::opMult, as[i], bs[i], 5'd0);
			runOp(exuPkg::opMfhi, $urandom(), $urandom(), 5'd0);
			runOp(exuPkg::opMflo, $urandom(), $urandom(), 5'd0);
			runOp(exuPkg::opMultu, as[i], bs[i], 5'd0);
			runOp(exuPkg::opMfhi, $urandom(), $urandom(), 5'd0);
			runOp(exuPkg::opMflo, $urandom(), $urandom(), 5'd0);
		end
	endtask

	// Issues in the busy cycles must leave no trace
	task automatic droppedIssueTest();
		logic [`EXU_DATA_W-1:0] a;
		logic [`EXU_DATA_W-1:0] b;
		logic [2*`EXU_DATA_W-1:0] p;
		int extra = 0;
		a = $urandom();
		b = $urandom();
		p = product(1'b1, a, b);
		@(negedge clk);
		waitNotBusy();
		issue  = 1'b1;
		aluCtl = exuPkg::opMult;
		opA    = a;
		opB    = b;
		@(negedge clk);
		checkValue("busy", 32'(busy), 32'd1);
		aluCtl = exuPkg::opMultu; // Dropped
		opA    = ~a;
		opB    = b + 1;
		@(negedge clk);
		checkValue("done", 32'(done), 32'd1);
		checkValue("busy", 32'(busy), 32'd1);
		checkValue("result", result, p[`EXU_DATA_W-1:0]);
		aluCtl = exuPkg::opMove; // Dropped in the done cycle
		@(negedge clk);
		issue = 1'b0;
		checkValue("busy", 32'(busy), 32'd0);
		for (int i = 0; i < 4; i++) begin
			if (done)
				extra++;
			checkValue("result", result, p[`EXU_DATA_W-1:0]); // Held through the drops
			@(negedge clk);
		end
		checkValue("extra done pulses", 32'(extra), 32'd0);
		{modelHi, modelLo} = p;
		runOp(exuPkg::opMfhi, $urandom(), $urandom(), 5'd0);
		runOp(exuPkg::opMflo, $urandom(), $urandom(), 5'd0);
	endtask

	task automatic moveTest();
		logic [`EXU_DATA_W-1:0] a;
		for (int i = 0; i < 3; i++) begin
			a = (i == 0) ? '0 : $urandom(); // First one checks zero
			runOp(exuPkg::opMove, a, $urandom(), 5'd0);
			runOp(exuPkg::opMfhi, $urandom(), $urandom(), 5'd0);
			runOp(exuPkg::opMflo, $urandom(), $urandom(), 5'd0);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(32'hbcabc3d2));
		rstN   = 1'b0;
		issue  = 1'b0;
		aluCtl = exuPkg::opAdd;
		opA    = '0;
		opB    = '0;
		shamt  = '0;
		repeat (5) @(posedge clk); // Reset for 5 cycles
		@(negedge clk);
		rstN = 1'b1;
		resetTest();
		aluStreamTest();
		shiftTest();
		multTest();
		droppedIssueTest();
		moveTest();
		@(negedge clk);
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, dut0.asserts0.assertFails);
		if (mismatches == 0 && timeouts == 0 && dut0.asserts0.assertFails == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: executeUnit.f
+incdir+verilog
verilog/exuPkg.sv
verilog/exuControl.sv
verilog/aluCore.sv
verilog/barrelShifter.sv
verilog/mulHiLo.sv
verilog/stageReg.sv
verilog/executeUnit.sv
tb/executeUnit_asserts.sv
tb/executeUnitTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module executeUnitTb \
	-f executeUnit.f -o executeUnitSim

out=$(./obj_dir/executeUnitSim +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation passed"; then
	exit 0
else
	exit 1
fi
